/* design/undo_log_settings.svh */
`ifndef UNDO_LOG_SETTINGS_SVH
`define UNDO_LOG_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tile sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// cores that log speculative stores
`define UNDO_N_CORES 4

// commit-queue slots, as log2
`define UNDO_SLOTS_LOG2 3

// undo entries per slot, as log2
`define UNDO_ENTRIES_LOG2 2

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define UNDO_ADDR_W 32
`define UNDO_DATA_W 32
`define UNDO_TAG_W 4

`endif

/* design/undo_log_pkg.sv */
`include "undo_log_settings.svh"

package undo_log_pkg;

   // basic fields
   typedef logic [`UNDO_SLOTS_LOG2-1:0] cq_slot_t;
   typedef logic [`UNDO_ENTRIES_LOG2-1:0] undo_id_t;
   typedef logic [$clog2(`UNDO_N_CORES)-1:0] core_sel_t;
   typedef logic [`UNDO_ADDR_W-1:0] addr_t;
   typedef logic [`UNDO_DATA_W-1:0] data_t;
   typedef logic [`UNDO_TAG_W-1:0] restore_tag_t;

   // one logged store, old value included
   typedef struct packed {
      cq_slot_t slot;
      undo_id_t id;
      addr_t    addr;
      data_t    data;
   } undo_entry_t;

   // abort of one task
   typedef struct packed {
      cq_slot_t     slot;
      restore_tag_t tag;
   } restore_req_t;

   typedef struct packed {
      cq_slot_t     slot;
      restore_tag_t tag;
   } restore_done_t;

   // write-back to memory
   typedef struct packed {
      addr_t addr;
      data_t data;
   } mem_write_t;

endpackage

/* design/undo_capture.sv */
`timescale 1ns/1ns
`include "undo_log_settings.svh"

module undo_capture (
   input  logic                                          clk,
   input  logic                                          rstn,
   input  logic [`UNDO_N_CORES-1:0]                      undo_valid,
   input  undo_log_pkg::undo_entry_t [`UNDO_N_CORES-1:0] undo_entry,
   output logic [`UNDO_N_CORES-1:0]                      undo_ready,
   output logic                                          log_wr_valid,
   output undo_log_pkg::undo_entry_t                     log_wr_entry
);
   import undo_log_pkg::*;

   core_sel_t sel;
   logic      any_valid;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // lowest index wins
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb begin
      sel = '0;
      any_valid = 1'b0;
      // scan down so the last hit is the lowest core
      for (int i = `UNDO_N_CORES - 1; i >= 0; i--) begin
         if (undo_valid[i]) begin
            sel = core_sel_t'(i);
            any_valid = 1'b1;
         end
      end
   end

   // never stalls, the winner always gets through
   always_comb begin
      undo_ready = '0;
      if (any_valid) begin
         undo_ready[sel] = 1'b1;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // pipeline stage toward the store
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk) begin
      if (!rstn) begin
         log_wr_valid <= 1'b0;
      end else begin
         log_wr_valid <= any_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (any_valid) begin
         log_wr_entry <= undo_entry[sel];
      end
   end

endmodule

/* design/undo_log_store.sv */
`timescale 1ns/1ns
`include "undo_log_settings.svh"

module undo_log_store (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      log_wr_valid,
   input  undo_log_pkg::undo_entry_t log_wr_entry,
   input  logic                      finish_valid,
   input  undo_log_pkg::cq_slot_t    finish_slot,
   input  logic                      finish_wrote,
   input  undo_log_pkg::cq_slot_t    rd_slot,
   input  undo_log_pkg::undo_id_t    rd_id,
   output undo_log_pkg::undo_entry_t rd_entry,
   output undo_log_pkg::undo_id_t    rd_last_id,
   output logic                      rd_written
);
   import undo_log_pkg::*;

   localparam int N_SLOTS = 1 << `UNDO_SLOTS_LOG2;
   localparam int DEPTH   = N_SLOTS << `UNDO_ENTRIES_LOG2;
   localparam int IDX_W   = `UNDO_SLOTS_LOG2 + `UNDO_ENTRIES_LOG2;

   addr_t              addr_mem [DEPTH];
   data_t              data_mem [DEPTH];
   undo_id_t           last_id  [N_SLOTS];
   logic [N_SLOTS-1:0] written;
   logic [IDX_W-1:0]   wr_idx;
   logic [IDX_W-1:0]   rd_idx;

   // slot in the upper bits, entry number below
   assign wr_idx = {log_wr_entry.slot, log_wr_entry.id};
   assign rd_idx = {rd_slot, rd_id};

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // log write
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk) begin
      if (log_wr_valid) begin
         addr_mem[wr_idx] <= log_wr_entry.addr;
         data_mem[wr_idx] <= log_wr_entry.data;
      end
   end

   // entries arrive in id order, so the newest one is the last
   always_ff @(posedge clk) begin
      if (log_wr_valid) begin
         last_id[log_wr_entry.slot] <= log_wr_entry.id;
      end
   end

   // task finish tells whether the slot logged anything
   always_ff @(posedge clk) begin
      if (!rstn) begin
         written <= '0;
      end else if (finish_valid) begin
         written[finish_slot] <= finish_wrote;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // read port for the restore engine
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk) begin
      rd_entry.slot <= rd_slot;
      rd_entry.id   <= rd_id;
      rd_entry.addr <= addr_mem[rd_idx];
      rd_entry.data <= data_mem[rd_idx];
   end

   // slot state is needed in the same cycle as the request
   assign rd_last_id = last_id[rd_slot];
   assign rd_written = written[rd_slot];

endmodule

/* design/undo_restore.sv */
`timescale 1ns/1ns

module undo_restore (
   input  logic                        clk,
   input  logic                        rstn,
   input  logic                        restore_req_valid,
   output logic                        restore_req_ready,
   input  undo_log_pkg::restore_req_t  restore_req,
   output undo_log_pkg::cq_slot_t      rd_slot,
   output undo_log_pkg::undo_id_t      rd_id,
   input  undo_log_pkg::undo_entry_t   rd_entry,
   input  undo_log_pkg::undo_id_t      rd_last_id,
   input  logic                        rd_written,
   output logic                        mem_wr_valid,
   input  logic                        mem_wr_ready,
   output undo_log_pkg::mem_write_t    mem_wr,
   input  logic                        mem_ack,
   output logic                        restore_done_valid,
   input  logic                        restore_done_ready,
   output undo_log_pkg::restore_done_t restore_done
);
   import undo_log_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_READ,
      ST_WRITE,
      ST_DONE
   } state_t;

   // one bit wider than an id, holds last_id + 1
   typedef logic [$bits(undo_id_t):0] ack_cnt_t;

   state_t       state;
   restore_req_t cur;
   undo_id_t     idx;
   undo_id_t     last_q;
   ack_cnt_t     ack_cnt;
   ack_cnt_t     ack_target;
   logic         req_fire;
   logic         wr_fire;
   logic         done_fire;

   assign restore_req_ready = (state == ST_IDLE);
   assign req_fire  = restore_req_valid & restore_req_ready;
   assign wr_fire   = mem_wr_valid & mem_wr_ready;
   assign done_fire = restore_done_valid & restore_done_ready;

   // idle points at the incoming slot so its written flag is seen at once
   assign rd_slot = (state == ST_IDLE) ? restore_req.slot : cur.slot;
   assign rd_id   = idx;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // restore FSM
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: begin
               if (req_fire) begin
                  state <= rd_written ? ST_READ : ST_DONE;
               end
            end
            ST_READ: begin
               state <= ST_WRITE;
            end
            ST_WRITE: begin
               if (mem_wr_ready) begin
                  state <= (idx == last_q) ? ST_DONE : ST_READ;
               end
            end
            ST_DONE: begin
               if (done_fire) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // entry index, steps after each accepted write
   always_ff @(posedge clk) begin
      if (!rstn) begin
         idx <= '0;
      end else if (req_fire) begin
         idx <= '0;
      end else if (wr_fire && idx != last_q) begin
         idx <= idx + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (req_fire) begin
         cur    <= restore_req;
         last_q <= rd_last_id;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // acknowledge tracking
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // unwritten slot expects no acks at all
   always_ff @(posedge clk) begin
      if (!rstn) begin
         ack_cnt    <= '0;
         ack_target <= '0;
      end else if (req_fire) begin
         ack_cnt    <= '0;
         ack_target <= rd_written ? {1'b0, rd_last_id} + 1'b1 : '0;
      end else if (mem_ack) begin
         ack_cnt <= ack_cnt + 1'b1;
      end
   end

   // write data comes straight from the store read register
   assign mem_wr_valid = (state == ST_WRITE);
   assign mem_wr.addr  = rd_entry.addr;
   assign mem_wr.data  = rd_entry.data;

   // done waits for the last ack
   assign restore_done_valid = (state == ST_DONE) && (ack_cnt == ack_target);
   assign restore_done.slot  = cur.slot;
   assign restore_done.tag   = cur.tag;

endmodule

/* design/undo_log_top.sv */
`timescale 1ns/1ns
`include "undo_log_settings.svh"

module undo_log_top (
   input  logic                                          clk,
   input  logic                                          rstn,
   input  logic [`UNDO_N_CORES-1:0]                      undo_valid,
   input  undo_log_pkg::undo_entry_t [`UNDO_N_CORES-1:0] undo_entry,
   output logic [`UNDO_N_CORES-1:0]                      undo_ready,
   input  logic                                          finish_valid,
   input  undo_log_pkg::cq_slot_t                        finish_slot,
   input  logic                                          finish_wrote,
   input  logic                                          restore_req_valid,
   output logic                                          restore_req_ready,
   input  undo_log_pkg::restore_req_t                    restore_req,
   output logic                                          restore_done_valid,
   input  logic                                          restore_done_ready,
   output undo_log_pkg::restore_done_t                   restore_done,
   output logic                                          mem_wr_valid,
   input  logic                                          mem_wr_ready,
   output undo_log_pkg::mem_write_t                      mem_wr,
   input  logic                                          mem_ack
);
   import undo_log_pkg::*;

   // capture to store
   logic        log_wr_valid;
   undo_entry_t log_wr_entry;

   // store to restore engine
   cq_slot_t    rd_slot;
   undo_id_t    rd_id;
   undo_entry_t rd_entry;
   undo_id_t    rd_last_id;
   logic        rd_written;

   undo_capture u_capture (
      .clk, .rstn, .undo_valid, .undo_entry, .undo_ready, .log_wr_valid, .log_wr_entry
   );

   undo_log_store u_store (
      .clk, .rstn, .log_wr_valid, .log_wr_entry, .finish_valid, .finish_slot, .finish_wrote,
      .rd_slot, .rd_id, .rd_entry, .rd_last_id, .rd_written
   );

   undo_restore u_restore (
      .clk, .rstn, .restore_req_valid, .restore_req_ready, .restore_req,
      .rd_slot, .rd_id, .rd_entry, .rd_last_id, .rd_written,
      .mem_wr_valid, .mem_wr_ready, .mem_wr, .mem_ack,
      .restore_done_valid, .restore_done_ready, .restore_done
   );

endmodule

/* bench/undo_log_assertions.sv */
`timescale 1ns/1ns
`include "undo_log_settings.svh"

module undo_log_assertions (
   input logic                        clk,
   input logic                        rstn,
   input logic [`UNDO_N_CORES-1:0]    valid,
   input logic [`UNDO_N_CORES-1:0]    ready,
   input logic                        wr_valid,
   input logic                        wr_ready,
   input undo_log_pkg::mem_write_t    wr,
   input logic                        done_valid,
   input logic                        done_ready,
   input undo_log_pkg::restore_done_t done
);
   bit fired = 1'b0;

   // one grant at a time
   one_grant: assert property (@(posedge clk) disable iff (!rstn) $onehot0(ready))
      else begin
         $error("more than one undo_ready bit high");
         fired = 1'b1;
      end

   grant_needs_valid: assert property (@(posedge clk) disable iff (!rstn)
      (ready & ~valid) == '0)
      else begin
         $error("undo_ready given to a core that is not valid");
         fired = 1'b1;
      end

   // stalled write holds
   write_stable: assert property (@(posedge clk) disable iff (!rstn)
      wr_valid && !wr_ready |=> wr_valid && $stable(wr))
      else begin
         $error("memory write changed while stalled");
         fired = 1'b1;
      end

   done_stable: assert property (@(posedge clk) disable iff (!rstn)
      done_valid && !done_ready |=> done_valid && $stable(done))
      else begin
         $error("restore done changed while stalled");
         fired = 1'b1;
      end

endmodule

bind undo_capture undo_log_assertions u_capture_sva (
   .clk, .rstn, .valid(undo_valid), .ready(undo_ready),
   .wr_valid(1'b0), .wr_ready(1'b1), .wr('0),
   .done_valid(1'b0), .done_ready(1'b1), .done('0)
);

bind undo_restore undo_log_assertions u_restore_sva (
   .clk, .rstn, .valid('0), .ready('0),
   .wr_valid(mem_wr_valid), .wr_ready(mem_wr_ready), .wr(mem_wr),
   .done_valid(restore_done_valid), .done_ready(restore_done_ready), .done(restore_done)
);

/* bench/undo_log_tb.sv */
`timescale 1ns/1ns
`include "undo_log_settings.svh"

module undo_log_tb;
   import undo_log_pkg::*;

   localparam int N       = `UNDO_N_CORES;
   localparam int N_SLOTS = 1 << `UNDO_SLOTS_LOG2;
   localparam int N_STEPS = 14;

   typedef enum int {LOG, FINISH, RESTORE} kind_t;

   typedef struct {
      string        name;
      kind_t        kind;
      logic [N-1:0] mask;
      cq_slot_t     slot;
      logic         flag;
      restore_tag_t tag;
      int           n_writes;
      logic         stall;
   } step_t;

   typedef struct {
      string         name;
      restore_done_t done;
      int            writes;
   } expect_done_t;

   // name, kind, core mask, slot, wrote (finish) or wait for done (restore), tag,
   // expected writes, back-pressure
   step_t steps [N_STEPS] = '{
      '{"log_slot1",           LOG,     4'b0001, 3'd1, 1'b0, 4'h0, 0, 1'b0},
      '{"log_slot1_multi",     LOG,     4'b1110, 3'd1, 1'b0, 4'h0, 0, 1'b0},
      '{"finish_slot1",        FINISH,  4'b0000, 3'd1, 1'b1, 4'h0, 0, 1'b0},
      '{"restore_slot1",       RESTORE, 4'b0000, 3'd1, 1'b1, 4'h5, 4, 1'b0},
      '{"log_slot2",           LOG,     4'b0011, 3'd2, 1'b0, 4'h0, 0, 1'b0},
      '{"finish_slot2",        FINISH,  4'b0000, 3'd2, 1'b1, 4'h0, 0, 1'b0},
      '{"log_slot3",           LOG,     4'b0100, 3'd3, 1'b0, 4'h0, 0, 1'b0},
      '{"finish_slot3_clear",  FINISH,  4'b0000, 3'd3, 1'b0, 4'h0, 0, 1'b0},
      '{"restore_unwritten",   RESTORE, 4'b0000, 3'd3, 1'b1, 4'ha, 0, 1'b0},
      '{"log_slot5",           LOG,     4'b1111, 3'd5, 1'b0, 4'h0, 0, 1'b0},
      '{"finish_slot5",        FINISH,  4'b0000, 3'd5, 1'b1, 4'h0, 0, 1'b0},
      '{"restore_slot2_stall", RESTORE, 4'b0000, 3'd2, 1'b0, 4'h7, 2, 1'b1},
      '{"log_slot6_in_flight", LOG,     4'b1000, 3'd6, 1'b0, 4'h0, 0, 1'b0},
      '{"restore_slot5_b2b",   RESTORE, 4'b0000, 3'd5, 1'b1, 4'hc, 4, 1'b1}
   };

   logic clk;
   logic rstn;
   logic [N-1:0] undo_valid, undo_ready;
   undo_entry_t [N-1:0] undo_entry;
   logic finish_valid, finish_wrote;
   cq_slot_t finish_slot;
   logic restore_req_valid, restore_req_ready;
   restore_req_t restore_req;
   logic restore_done_valid, restore_done_ready;
   restore_done_t restore_done;
   logic mem_wr_valid, mem_wr_ready, mem_ack;
   mem_write_t mem_wr;

   int           seed = 32'h33b6_7328;
   int           cycle = 0;
   logic         stall = 1'b0;
   int           ack_due [$];
   logic [31:0]  mem_model [logic [31:0]];
   mem_write_t   ref_log [N_SLOTS][$];
   logic         ref_written [N_SLOTS] = '{default: 1'b0};
   mem_write_t   exp_wr [$];
   mem_write_t   restored [$];
   expect_done_t done_q [$];
   int           wr_total = 0;
   int           n_wr = 0;
   int           n_ack = 0;

   undo_log_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic stop_with_failure(string why);
      $display("%s", why);
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   task automatic expect_equal(string name, logic [63:0] expected, logic [63:0] actual);
      if (expected !== actual) begin
         stop_with_failure($sformatf("FAILED %s: expected %0h, actual %0h",
                                     name, expected, actual));
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // step drivers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // ids follow core index, the order the arbiter should take them in
   task automatic log_entries(step_t st);
      logic [N-1:0] pending;
      logic [N-1:0] lowest;
      undo_entry_t  e;
      for (int i = 0; i < N; i++) begin
         if (st.mask[i]) begin
            e.slot = st.slot;
            e.id   = undo_id_t'(ref_log[st.slot].size());
            e.addr = 32'h4000_0000 + 32'(st.slot) * 32'h100 + 32'(e.id) * 4;
            e.data = $random(seed);
            undo_entry[i] <= e;
            ref_log[st.slot].push_back('{e.addr, e.data});
         end
      end
      pending = st.mask;
      undo_valid <= pending;
      while (pending != '0) begin
         @(posedge clk);
         lowest = pending & (~pending + 1'b1);
         expect_equal({st.name, ": undo_ready"}, lowest, undo_ready);
         pending = pending & ~lowest;
         undo_valid <= pending;
      end
   endtask

   task automatic mark_finished(step_t st);
      finish_valid <= 1'b1;
      finish_slot  <= st.slot;
      finish_wrote <= st.flag;
      ref_written[st.slot] = st.flag;
      @(posedge clk);
      finish_valid <= 1'b0;
   endtask

   task automatic request_restore(step_t st);
      int n;
      n = 0;
      if (ref_written[st.slot]) begin
         n = ref_log[st.slot].size();
         for (int i = 0; i < n; i++) begin
            exp_wr.push_back(ref_log[st.slot][i]);
            restored.push_back(ref_log[st.slot][i]);
         end
      end
      ref_log[st.slot].delete();
      wr_total += st.n_writes;
      done_q.push_back('{st.name, '{st.slot, st.tag}, wr_total});
      stall             <= st.stall;
      restore_req_valid <= 1'b1;
      restore_req       <= '{st.slot, st.tag};
      do @(posedge clk); while (!restore_req_ready);
      restore_req_valid <= 1'b0;
      if (st.flag) begin
         while (done_q.size() != 0) @(posedge clk);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // memory model and monitor
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // acks leave in write order, 1 to 4 cycles late
   always @(posedge clk) begin
      if (rstn) begin
         if (mem_wr_valid && mem_wr_ready) begin
            mem_model[mem_wr.addr] = mem_wr.data;
            ack_due.push_back(cycle + 1 + $unsigned($random(seed)) % 4);
         end
         mem_ack <= (ack_due.size() > 0) && (ack_due[0] <= cycle);
         if ((ack_due.size() > 0) && (ack_due[0] <= cycle)) begin
            void'(ack_due.pop_front());
         end
         mem_wr_ready       <= !stall || ($random(seed) & 1);
         restore_done_ready <= !stall || ($random(seed) & 1);
      end
   end

   always @(posedge clk) begin
      if (rstn) begin
         if (mem_wr_valid && mem_wr_ready) begin
            if (exp_wr.size() == 0) begin
               stop_with_failure("memory write issued with no restore write expected");
            end
            expect_equal({done_q[0].name, ": memory write"}, exp_wr[0], mem_wr);
            void'(exp_wr.pop_front());
            n_wr++;
         end
         // acks of earlier edges only, done may not rise before the last one
         if (restore_done_valid) begin
            if (done_q.size() == 0) begin
               stop_with_failure("restore done reported with no request pending");
            end
            expect_equal({done_q[0].name, ": writes before done"}, done_q[0].writes, n_wr);
            expect_equal({done_q[0].name, ": acks before done"}, done_q[0].writes, n_ack);
         end
         if (restore_done_valid && restore_done_ready) begin
            expect_equal({done_q[0].name, ": done slot and tag"}, done_q[0].done, restore_done);
            void'(done_q.pop_front());
         end
         if (mem_ack) begin
            n_ack++;
         end
      end
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle > N_STEPS * 64) begin
         stop_with_failure($sformatf("timeout: run did not end within %0d cycles", cycle));
      end
      if (DUT.u_capture.u_capture_sva.fired || DUT.u_restore.u_restore_sva.fired) begin
         stop_with_failure("a bound handshake assertion failed");
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // main sequence
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   initial begin
      rstn = 1'b0;
      undo_valid = '0;
      undo_entry = '0;
      finish_valid = 1'b0;
      finish_slot = '0;
      finish_wrote = 1'b0;
      restore_req_valid = 1'b0;
      restore_req = '0;
      restore_done_ready = 1'b0;
      mem_wr_ready = 1'b0;
      mem_ack = 1'b0;
      repeat (2) @(posedge clk);
      rstn <= 1'b1;
      @(posedge clk);
      expect_equal("reset: restore_req_ready", 1'b1, restore_req_ready);
      expect_equal("reset: undo_ready", '0, undo_ready);
      expect_equal("reset: mem_wr_valid", 1'b0, mem_wr_valid);
      expect_equal("reset: restore_done_valid", 1'b0, restore_done_valid);
      foreach (steps[s]) begin
         @(posedge clk);
         case (steps[s].kind)
            LOG:     log_entries(steps[s]);
            FINISH:  mark_finished(steps[s]);
            default: request_restore(steps[s]);
         endcase
      end
      while (done_q.size() != 0) @(posedge clk);
      foreach (restored[i]) begin
         expect_equal("memory contents", restored[i].data, mem_model[restored[i].addr]);
      end
      if (DUT.u_capture.u_capture_sva.fired || DUT.u_restore.u_restore_sva.fired) begin
         stop_with_failure("a bound handshake assertion failed");
      end else begin
         $display("SIMULATION PASSED");
         $finish;
      end
   end

endmodule

/* undo_log_top.f */
+incdir+design
design/undo_log_pkg.sv
design/undo_capture.sv
design/undo_log_store.sv
design/undo_restore.sv
design/undo_log_top.sv
bench/undo_log_assertions.sv
bench/undo_log_tb.sv

/* Bender.yml */
package:
  name: undo_log

export_include_dirs:
  - design

sources:
  - design/undo_log_pkg.sv
  - design/undo_capture.sv
  - design/undo_log_store.sv
  - design/undo_restore.sv
  - design/undo_log_top.sv
  - target: test
    files:
      - bench/undo_log_assertions.sv
      - bench/undo_log_tb.sv
